/* Makefile */
TOP := tb_reward_logic

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

/* build.f */
hdl/reward_pkg.sv
hdl/reward_spawner.sv
hdl/reward_slot.sv
hdl/reward_effect.sv
hdl/reward_logic.sv
testbench/reward_logic_sva.sv
testbench/tb_reward_logic.sv

/* hdl/reward_effect.sv */
/*
 * Reward effect stage: catches head contact or a switch override,
 * times the active effect and drives effect flags and LEDs.
 */

`timescale 1ns/1ps
`default_nettype none

module reward_effect
(
	input  logic                                clk_4Hz,
	input  logic                                rst_n,
	input  reward_pkg::game_status_t            status,
	input  logic [reward_pkg::GRID_BITS-1:0]    head_x,
	input  logic [reward_pkg::GRID_BITS-1:0]    head_y,
	input  logic [2:0]                          sw,
	input  logic                                slot_valid,
	input  reward_pkg::reward_item_t            slot_item,
	output logic                                eaten,
	output reward_pkg::effect_flags_t           effects,
	output logic [15:0]                         led
);
	import reward_pkg::*;

	typedef enum logic [2:0]
	{
		ph_idle,
		ph_shield,
		ph_slow,
		ph_recover,
		ph_bonus
	} phase_t;

	phase_t                phase;
	phase_t                sw_phase;
	phase_t                hit_phase;
	logic [TIMER_BITS-1:0] timer;
	logic                  head_hit;
	logic                  running;

	// reload value for a phase, one less than its duration
	function automatic logic [TIMER_BITS-1:0] ticks_of(phase_t ph);
		case (ph)
			ph_shield:  return TIMER_BITS'(SHIELD_TICKS - 1);
			ph_slow:    return TIMER_BITS'(SLOW_TICKS - 1);
			ph_recover: return TIMER_BITS'(RECOVER_TICKS - 1);
			ph_bonus:   return TIMER_BITS'(BONUS_TICKS - 1);
			default:    return '0;
		endcase
	endfunction

	assign running = (status == game_run);

	// override needs exactly one switch up
	always_comb
	begin
		case (sw)
			3'b001:  sw_phase = ph_shield;
			3'b010:  sw_phase = ph_slow;
			3'b100:  sw_phase = ph_bonus;
			default: sw_phase = ph_idle;
		endcase
	end

	always_comb
	begin
		case (slot_item.kind)
			kind_shield: hit_phase = ph_shield;
			kind_slow:   hit_phase = ph_slow;
			kind_bonus:  hit_phase = ph_bonus;
			default:     hit_phase = ph_idle;
		endcase
	end

	assign head_hit = slot_valid
		&& (head_x == slot_item.x)
		&& (head_y == slot_item.y)
		&& (hit_phase != ph_idle);

	always_ff @(posedge clk_4Hz)
	begin
		if (!rst_n || !running)
		begin
			phase <= ph_idle;
			timer <= '0;
			eaten <= 1'b0;
		end
		else
		begin
			eaten <= 1'b0;
			if (phase == ph_idle)
			begin
				// switches win over the head and leave the slot alone
				if (sw_phase != ph_idle)
				begin
					phase <= sw_phase;
					timer <= ticks_of(sw_phase);
				end
				else if (head_hit)
				begin
					phase <= hit_phase;
					timer <= ticks_of(hit_phase);
					eaten <= 1'b1;
				end
			end
			else if (timer != '0)
			begin
				timer <= timer - 1'b1;
			end
			else if (phase == ph_slow)
			begin
				// slow hands over to speed recovery on the same edge
				phase <= ph_recover;
				timer <= ticks_of(ph_recover);
			end
			else
			begin
				phase <= ph_idle;
			end
		end
	end

	always_comb
	begin
		effects               = '0;
		led                   = '0;
		case (phase)
			ph_shield:
			begin
				effects.shield = 1'b1;
				led            = LED_SHIELD;
			end
			ph_slow:
			begin
				effects.slow = 1'b1;
				led          = LED_SLOW;
			end
			ph_bonus:
			begin
				effects.bonus = 1'b1;
				led           = LED_BONUS;
			end
			ph_recover: effects.speed_recover = 1'b1;
			default:    effects = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/reward_logic.sv */
/*
 * Reward subsystem top: spawner feeds the slot, the effect stage
 * consumes the pending reward and drives flags and LEDs.
 */

`timescale 1ns/1ps
`default_nettype none

module reward_logic
(
	input  logic                             clk_4Hz,
	input  logic                             rst_n,
	input  reward_pkg::game_status_t         game_status,
	input  logic [reward_pkg::GRID_BITS-1:0] head_x,
	input  logic [reward_pkg::GRID_BITS-1:0] head_y,
	input  logic [2:0]                       sw,
	output reward_pkg::reward_item_t         pending,
	output logic                             reward_ready,
	output reward_pkg::effect_flags_t        effects,
	output logic [15:0]                      led
);
	import reward_pkg::*;

	logic         spawn_strobe;
	reward_item_t spawn_item;
	logic         eaten;

	reward_spawner reward_spawner_i
	(
		.clk_4Hz      (clk_4Hz),
		.rst_n        (rst_n),
		.status       (game_status),
		.slot_valid   (reward_ready),
		.spawn_strobe (spawn_strobe),
		.spawn_item   (spawn_item)
	);

	reward_slot reward_slot_i
	(
		.clk_4Hz      (clk_4Hz),
		.rst_n        (rst_n),
		.status       (game_status),
		.spawn_strobe (spawn_strobe),
		.spawn_item   (spawn_item),
		.eaten        (eaten),
		.valid        (reward_ready),
		.item         (pending)
	);

	reward_effect reward_effect_i
	(
		.clk_4Hz    (clk_4Hz),
		.rst_n      (rst_n),
		.status     (game_status),
		.head_x     (head_x),
		.head_y     (head_y),
		.sw         (sw),
		.slot_valid (reward_ready),
		.slot_item  (pending),
		.eaten      (eaten),
		.effects    (effects),
		.led        (led)
	);

endmodule

`default_nettype wire

/* hdl/reward_pkg.sv */
/*
 * Reward subsystem package: grid, durations, LED patterns,
 * status and kind enums, and the reward and effect structs.
 */

`default_nettype none

package reward_pkg;

	// playfield is 64 x 64 cells
	localparam int GRID_BITS = 6;

	// effect durations, in clk_4Hz ticks
	localparam int SHIELD_TICKS  = 30;
	localparam int SLOW_TICKS    = 30;
	localparam int RECOVER_TICKS = 10;
	// score bonus ran a step-of-5 counter up to 30
	localparam int BONUS_TICKS   = 6;

	// wide enough for the longest duration
	localparam int TIMER_BITS = 6;

	// LED bars, one nibble per effect
	localparam logic [15:0] LED_SHIELD = 16'b0000_0000_0000_1111;
	localparam logic [15:0] LED_SLOW   = 16'b0000_0000_1111_0000;
	localparam logic [15:0] LED_BONUS  = 16'b0000_1111_0000_0000;

	// any nonzero value works
	localparam logic [15:0] LFSR_SEED = 16'hace1;

	// run keeps the old 2'b10 code
	typedef enum logic [1:0]
	{
		game_idle = 2'b00,
		game_run  = 2'b10,
		game_over = 2'b11
	} game_status_t;

	typedef enum logic [1:0]
	{
		kind_none   = 2'd0,
		kind_shield = 2'd1,
		kind_slow   = 2'd2,
		kind_bonus  = 2'd3
	} reward_kind_t;

	// one reward on the grid
	typedef struct packed
	{
		reward_kind_t         kind;
		logic [GRID_BITS-1:0] x;
		logic [GRID_BITS-1:0] y;
	} reward_item_t;

	// at most one flag is high at a time
	typedef struct packed
	{
		logic shield;
		logic slow;
		logic bonus;
		logic speed_recover;
	} effect_flags_t;

endpackage

`default_nettype wire

/* hdl/reward_slot.sv */
/*
 * Reward slot: one-entry store for the pending reward, loaded by the
 * spawner and emptied when eaten or when play stops.
 */

`timescale 1ns/1ps
`default_nettype none

module reward_slot
(
	input  logic                     clk_4Hz,
	input  logic                     rst_n,
	input  reward_pkg::game_status_t status,
	input  logic                     spawn_strobe,
	input  reward_pkg::reward_item_t spawn_item,
	input  logic                     eaten,
	output logic                     valid,
	output reward_pkg::reward_item_t item
);
	import reward_pkg::*;

	always_ff @(posedge clk_4Hz)
	begin
		if (!rst_n)
		begin
			valid <= 1'b0;
		end
		else if (status != game_run)
		begin
			valid <= 1'b0;
		end
		else if (eaten)
		begin
			valid <= 1'b0;
		end
		else if (spawn_strobe)
		begin
			valid <= 1'b1;
		end
	end

	// pending reads zero until the first spawn,
	// then keeps the last reward while the slot is empty
	always_ff @(posedge clk_4Hz)
	begin
		if (!rst_n)
		begin
			item <= '0;
		end
		else if (spawn_strobe)
		begin
			item <= spawn_item;
		end
	end

endmodule

`default_nettype wire

/* hdl/reward_spawner.sv */
/*
 * Reward spawner: steps a 16-bit Galois LFSR while the game runs and
 * offers a random reward kind and position whenever the slot is empty.
 */

`timescale 1ns/1ps
`default_nettype none

module reward_spawner
(
	input  logic                     clk_4Hz,
	input  logic                     rst_n,
	input  reward_pkg::game_status_t status,
	input  logic                     slot_valid,
	output logic                     spawn_strobe,
	output reward_pkg::reward_item_t spawn_item
);
	import reward_pkg::*;

	// right-shift form of x^16 + x^14 + x^13 + x^11 + 1
	localparam logic [15:0] TAPS = 16'hb400;

	logic [15:0] lfsr;
	logic [15:0] lfsr_next;
	logic        valid_d;
	logic        running;

	assign running = (status == game_run);

	always_comb
	begin
		lfsr_next = {1'b0, lfsr[15:1]};
		if (lfsr[0])
		begin
			lfsr_next = lfsr_next ^ TAPS;
		end
	end

	always_ff @(posedge clk_4Hz)
	begin
		if (!rst_n)
		begin
			lfsr    <= LFSR_SEED;
			valid_d <= 1'b0;
		end
		else
		begin
			// draws only advance during play
			if (running)
			begin
				lfsr <= lfsr_next;
			end
			valid_d <= slot_valid;
		end
	end

	// kind from the top bits, position from two separate fields
	assign spawn_item.kind = reward_kind_t'(lfsr[15:14]);
	assign spawn_item.x    = lfsr[11:6];
	assign spawn_item.y    = lfsr[5:0];

	// valid_d holds off the first empty cycle, so the slot stays
	// empty for at least two cycles between rewards
	// a kind_none draw is simply skipped
	assign spawn_strobe = running
		&& !slot_valid
		&& !valid_d
		&& (spawn_item.kind != kind_none);

endmodule

`default_nettype wire

/* testbench/reward_logic_sva.sv */
/*
 * Reward subsystem assertions on the top-level outputs.
 */

`timescale 1ns/1ps
`default_nettype none

module reward_logic_sva
(
	input logic                      clk_4Hz,
	input logic                      rst_n,
	input reward_pkg::game_status_t  game_status,
	input logic                      reward_ready,
	input reward_pkg::effect_flags_t effects,
	input logic [15:0]               led
);
	import reward_pkg::*;

	// shield, slow, bonus and recovery exclude each other
	one_effect_a: assert property (@(posedge clk_4Hz) disable iff (!rst_n)
		$onehot0(effects))
		else $error("several effect flags high at once");

	// recovery alone lights nothing
	dark_led_a: assert property (@(posedge clk_4Hz) disable iff (!rst_n)
		!(effects.shield || effects.slow || effects.bonus) |-> (led == 16'h0000))
		else $error("led lit with no effect active");

	// slot is empty one edge after play stops
	idle_slot_a: assert property (@(posedge clk_4Hz) disable iff (!rst_n)
		(game_status != game_run) |=> !reward_ready)
		else $error("reward_ready high outside of play");

endmodule

bind reward_logic reward_logic_sva reward_logic_sva_i
(
	.clk_4Hz      (clk_4Hz),
	.rst_n        (rst_n),
	.game_status  (game_status),
	.reward_ready (reward_ready),
	.effects      (effects),
	.led          (led)
);

`default_nettype wire

/* testbench/tb_reward_logic.sv */
/*
 * Reward subsystem testbench: captures, second matches, misses,
 * switch overrides and leaving play, checked against a reference model.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_reward_logic;
	import reward_pkg::*;

	// expected outputs for one cycle
	typedef struct packed
	{
		effect_flags_t flags;
		logic [15:0]   led;
	} expect_t;

	logic                 clk_4Hz;
	logic                 rst_n;
	game_status_t         game_status;
	logic [GRID_BITS-1:0] head_x;
	logic [GRID_BITS-1:0] head_y;
	logic [2:0]           sw;
	reward_item_t         pending;
	logic                 reward_ready;
	effect_flags_t        effects;
	logic [15:0]          led;

	logic [15:0]  lfsr_state;
	reward_kind_t ref_kind;
	int           ref_tick;
	expect_t      expected;
	reward_item_t snap;
	logic [3:0]   kinds_seen;
	string        test_name;

	reward_logic reward_logic_i
	(
		.clk_4Hz      (clk_4Hz),
		.rst_n        (rst_n),
		.game_status  (game_status),
		.head_x       (head_x),
		.head_y       (head_y),
		.sw           (sw),
		.pending      (pending),
		.reward_ready (reward_ready),
		.effects      (effects),
		.led          (led)
	);

	initial
	begin
		clk_4Hz = 1'b0;
		forever
		begin
			#10 clk_4Hz = ~clk_4Hz;
		end
	end

	// expected flags and LEDs, tick counted from the capture edge
	function automatic expect_t effect_model(reward_kind_t kind, int tick);
		expect_t e;
		e = '0;
		if (kind == kind_shield && tick < SHIELD_TICKS)
		begin
			e.flags.shield = 1'b1;
			e.led          = LED_SHIELD;
		end
		else if (kind == kind_slow && tick < SLOW_TICKS)
		begin
			e.flags.slow = 1'b1;
			e.led        = LED_SLOW;
		end
		else if (kind == kind_slow && tick < SLOW_TICKS + RECOVER_TICKS)
			e.flags.speed_recover = 1'b1;
		else if (kind == kind_bonus && tick < BONUS_TICKS)
		begin
			e.flags.bonus = 1'b1;
			e.led         = LED_BONUS;
		end
		return e;
	endfunction

	// galois form of x^16 + x^15 + x^13 + x^4 + 1, one step per bit
	function automatic logic [15:0] take_bits(int n);
		logic [15:0] val;
		int          i;
		val = '0;
		for (i = 0; i < n; i++)
		begin
			val        = {val[14:0], lfsr_state[0]};
			lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hd008 : 16'h0000);
		end
		return val;
	endfunction

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(string what, logic [31:0] exp_val, logic [31:0] act_val);
		if (exp_val !== act_val)
			abort_run($sformatf("Error: %s/%s expected %0h actual %0h",
				test_name, what, exp_val, act_val));
	endtask

	always @(negedge clk_4Hz)
	begin
		if (rst_n)
		begin
			expected = effect_model(ref_kind, ref_tick);
			check_value("effects", 32'(expected.flags), 32'(effects));
			check_value("led", 32'(expected.led), 32'(led));
			ref_tick = ref_tick + 1;
		end
	end

	// call right after a rising edge
	task automatic move_head_off(reward_item_t avoid);
		logic [GRID_BITS-1:0] x;
		logic [GRID_BITS-1:0] y;
		x = GRID_BITS'(take_bits(GRID_BITS));
		y = GRID_BITS'(take_bits(GRID_BITS));
		if (x == avoid.x && y == avoid.y)
			x[0] = ~x[0];
		head_x <= x;
		head_y <= y;
	endtask

	task automatic wait_ready(int limit);
		int n;
		n = 0;
		@(negedge clk_4Hz);
		while (!reward_ready)
		begin
			n++;
			if (n > limit)
				abort_run("Timeout waiting for reward_ready to rise");
			@(negedge clk_4Hz);
		end
		snap = pending;
	endtask

	task automatic wait_effect_end();
		int n;
		n = 0;
		while (ref_tick <= SLOW_TICKS + RECOVER_TICKS)
		begin
			n++;
			if (n > 64)
				abort_run("Timeout waiting for the effect to finish");
			@(posedge clk_4Hz);
		end
	endtask

	task automatic eat_reward();
		reward_item_t target;
		int           n;
		target = snap;
		@(posedge clk_4Hz);
		head_x <= target.x;
		head_y <= target.y;
		// head match is sampled on this edge
		@(posedge clk_4Hz);
		ref_kind = target.kind;
		ref_tick = 0;
		kinds_seen[target.kind] = 1'b1;
		move_head_off(target);
		n = 0;
		@(negedge clk_4Hz);
		while (reward_ready)
		begin
			n++;
			if (n > 2)
				abort_run("reward_ready stayed high after the reward was eaten");
			@(negedge clk_4Hz);
		end
		n = 0;
		while (!reward_ready)
		begin
			n++;
			if (n > 200)
				abort_run("Timeout waiting for the next reward");
			@(negedge clk_4Hz);
		end
		check_value("ready_gap", 32'd1, 32'(n >= 2));
		snap = pending;
		@(posedge clk_4Hz);
		if (target.kind == kind_slow && ref_tick < SLOW_TICKS)
		begin
			// second match while slow runs is ignored
			head_x <= snap.x;
			head_y <= snap.y;
			repeat (4)
			begin
				@(negedge clk_4Hz);
				check_value("second_ready", 32'd1, 32'(reward_ready));
				check_value("second_pending", 32'(snap), 32'(pending));
			end
			@(posedge clk_4Hz);
		end
		move_head_off(snap);
		wait_effect_end();
	endtask

	task automatic force_effect(logic [2:0] value, reward_kind_t kind);
		reward_item_t held;
		held = snap;
		@(posedge clk_4Hz);
		sw <= value;
		@(posedge clk_4Hz);
		ref_kind = kind;
		ref_tick = 0;
		sw <= 3'b000;
		while (ref_tick <= SLOW_TICKS + RECOVER_TICKS)
		begin
			@(negedge clk_4Hz);
			check_value("sw_ready", 32'd1, 32'(reward_ready));
			check_value("sw_pending", 32'(held), 32'(pending));
			@(posedge clk_4Hz);
		end
	endtask

	initial
	begin
		logic [2:0]   sw_codes [3];
		reward_kind_t sw_kinds [3];
		int           n;
		int           start;
		sw_codes    = '{3'b001, 3'b010, 3'b100};
		sw_kinds    = '{kind_shield, kind_slow, kind_bonus};
		rst_n       = 1'b0;
		game_status = game_idle;
		head_x      = '0;
		head_y      = '0;
		sw          = 3'b000;
		ref_kind    = kind_none;
		ref_tick    = 0;
		lfsr_state  = 16'd17;
		kinds_seen  = '0;
		snap        = '0;
		test_name   = "reset";
		repeat (16) @(posedge clk_4Hz);
		rst_n <= 1'b1;

		test_name = "idle";
		repeat (10)
		begin
			@(negedge clk_4Hz);
			check_value("ready", 32'd0, 32'(reward_ready));
			check_value("pending", 32'd0, 32'(pending));
		end

		test_name = "capture";
		@(posedge clk_4Hz);
		game_status <= game_run;
		wait_ready(200);
		n = 0;
		while (kinds_seen[3:1] != 3'b111 && n < 24)
		begin
			eat_reward();
			n++;
		end
		// every reward kind has been eaten once
		check_value("kinds", 32'h7, 32'(kinds_seen[3:1]));

		test_name = "miss";
		repeat (8)
		begin
			@(posedge clk_4Hz);
			move_head_off(snap);
			@(negedge clk_4Hz);
			check_value("ready", 32'd1, 32'(reward_ready));
			check_value("pending", 32'(snap), 32'(pending));
		end

		test_name = "sw_override";
		start = int'(take_bits(2)) % 3;
		for (n = 0; n < 3; n++)
			force_effect(sw_codes[(start + n) % 3], sw_kinds[(start + n) % 3]);

		// two switches up start nothing
		test_name = "sw_two_bits";
		@(posedge clk_4Hz);
		ref_kind = kind_none;
		sw <= 3'b011;
		repeat (6) @(negedge clk_4Hz);
		@(posedge clk_4Hz);
		sw <= 3'b000;

		test_name = "game_over";
		@(posedge clk_4Hz);
		sw <= 3'b001;
		@(posedge clk_4Hz);
		ref_kind = kind_shield;
		ref_tick = 0;
		sw <= 3'b000;
		repeat (5) @(posedge clk_4Hz);
		game_status <= game_over;
		@(posedge clk_4Hz);
		ref_kind = kind_none;
		@(negedge clk_4Hz);
		check_value("ready", 32'd0, 32'(reward_ready));
		check_value("led", 32'd0, 32'(led));

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
